/* src/pkg_vec.sv */
// Shared types for a 4-lane SIMD unit; 32-bit lanes, 8 registers each, no memory path or handshake
`default_nettype none

package pkg_vec;

	////////////////////////////////////////
	// Geometry
	////////////////////////////////////////
	localparam int NUM_LANES	= 4;				// Lanes in the array
	localparam int DATA_W		= 32;				// Lane word width
	localparam int NUM_REGS		= 8;				// Registers per lane
	localparam int REG_IDX_W	= $clog2(NUM_REGS);	// Register index bits
	localparam int OPC_W		= 4;				// Opcode bits
	localparam int IMM_W		= 22;				// Immediate field bits
	localparam int RR_PAD_W		= DATA_W - OPC_W - 3*REG_IDX_W;	// Unused tail of rr form

	typedef logic [NUM_LANES-1:0]	lane_mask_t;	// One bit per lane
	typedef logic [DATA_W-1:0]		data_t;			// Lane data word
	typedef logic [REG_IDX_W-1:0]	reg_idx_t;		// Register index

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////
	typedef enum logic [OPC_W-1:0] {
		OP_NOP		= 4'd0,		// No operation
		OP_BCAST	= 4'd1,		// rd = scalar input
		OP_LANEID	= 4'd2,		// rd = lane index
		OP_ADD		= 4'd3,		// rd = rs1 + rs2
		OP_SUB		= 4'd4,		// rd = rs1 - rs2
		OP_AND		= 4'd5,		// rd = rs1 & rs2
		OP_XOR		= 4'd6,		// rd = rs1 ^ rs2
		OP_ADDI		= 4'd7,		// rd = rs1 + sext(imm)
		OP_ROT		= 4'd8,		// rd = rs1 of next lane up
		OP_REDUCE	= 4'd9		// No write, rs1 goes to sum
	} opcode_t;

	////////////////////////////////////////
	// Command word, two views of one word
	////////////////////////////////////////
	typedef struct packed {
		opcode_t					opcode;		// [31:28]
		reg_idx_t					rd;			// [27:25]
		reg_idx_t					rs1;		// [24:22]
		reg_idx_t					rs2;		// [21:19]
		logic [RR_PAD_W-1:0]		unused;		// [18:0] ignored
	} cmd_rr_t;

	typedef struct packed {
		opcode_t					opcode;		// [31:28]
		reg_idx_t					rd;			// [27:25]
		reg_idx_t					rs1;		// [24:22]
		logic signed [IMM_W-1:0]	imm;		// [21:0] two's complement
	} cmd_ri_t;

	typedef union packed {
		cmd_rr_t	rr;		// Register-register view
		cmd_ri_t	ri;		// Register-immediate view
	} cmd_word_t;

endpackage

`default_nettype wire

/* src/vec_issue.sv */
// Issue register for the vector unit; a zero lane mask means idle, the command is then dropped
`timescale 1ns/1ps
`default_nettype none

module vec_issue (
	input	wire					clock,
	input	wire					arst_n,
	input	pkg_vec::lane_mask_t	en_lane,		// Issue strobe, one bit per lane
	input	pkg_vec::cmd_word_t		command,		// Raw command word
	input	pkg_vec::data_t			scalar_in,		// Scalar for broadcast
	output	pkg_vec::lane_mask_t	iss_mask,		// Registered lane mask
	output	pkg_vec::opcode_t		iss_op,			// Registered opcode
	output	pkg_vec::reg_idx_t		iss_rd,			// Destination register
	output	pkg_vec::reg_idx_t		iss_rs1,		// Source 1
	output	pkg_vec::reg_idx_t		iss_rs2,		// Source 2
	output	pkg_vec::data_t			iss_imm,		// Sign-extended immediate
	output	pkg_vec::data_t			iss_scalar		// Registered scalar
);

	import pkg_vec::*;

	logic		issue;		// Any lane enabled
	opcode_t	dec_op;		// Opcode after idle forcing
	data_t		dec_imm;	// Immediate after sign extension

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////
	assign issue	= |en_lane;
	assign dec_op	= issue ? command.rr.opcode : OP_NOP;	// Idle cycle is a NOP

	// Only ADDI carries an immediate, other forms see zero
	assign dec_imm	= (dec_op == OP_ADDI)
					? {{(DATA_W-IMM_W){command.ri.imm[IMM_W-1]}}, command.ri.imm}
					: '0;

	////////////////////////////////////////
	// Issue register
	////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			iss_mask	<= '0;
			iss_op		<= OP_NOP;
			iss_rd		<= '0;
			iss_rs1		<= '0;
			iss_rs2		<= '0;
			iss_imm		<= '0;
			iss_scalar	<= '0;
		end else begin
			iss_mask	<= en_lane;
			iss_op		<= dec_op;
			iss_rd		<= command.rr.rd;		// Same bits in both views
			iss_rs1		<= command.rr.rs1;
			iss_rs2		<= command.rr.rs2;		// Garbage on ADDI, not read
			iss_imm		<= dec_imm;
			iss_scalar	<= scalar_in;
		end
	end

endmodule

`default_nettype wire

/* src/vec_lane.sv */
// One SIMD lane; reads are combinational, a write lands on the next edge and is seen right after
`timescale 1ns/1ps
`default_nettype none

module vec_lane #(
	parameter int LANE_ID = 0					// Position in the array, 0 to NUM_LANES-1
) (
	input	wire					clock,
	input	wire					arst_n,
	input	wire					en,			// Lane selected by the mask
	input	pkg_vec::opcode_t		op,			// Broadcast opcode
	input	pkg_vec::reg_idx_t		rd,			// Destination register
	input	pkg_vec::reg_idx_t		rs1,		// Source 1
	input	pkg_vec::reg_idx_t		rs2,		// Source 2
	input	pkg_vec::data_t			imm,		// Sign-extended immediate
	input	pkg_vec::data_t			scalar,		// Broadcast scalar
	input	pkg_vec::data_t			rot_in,		// rs1 of next lane up
	output	pkg_vec::data_t			rot_out,	// Own rs1 for lane below
	output	logic					commit,		// Command done in this lane
	output	logic					zero,		// Result or operand was zero
	output	pkg_vec::data_t			red_val,	// Reduce operand, else 0
	output	logic					red_flag	// Reduce happened
);

	import pkg_vec::*;

	data_t	regs [NUM_REGS];	// Lane register file
	data_t	src1;				// rs1 read port
	data_t	src2;				// rs2 read port
	data_t	result;				// ALU output
	data_t	chk_val;			// Value tested for zero
	logic	exec;				// Lane runs this command
	logic	is_red;				// Reduce in this lane
	logic	wr_en;				// Register write

	////////////////////////////////////////
	// Read ports and control
	////////////////////////////////////////
	assign src1		= regs[rs1];
	assign src2		= regs[rs2];
	assign rot_out	= src1;							// Feeds the ring

	assign exec		= en && (op != OP_NOP);
	assign is_red	= exec && (op == OP_REDUCE);
	assign wr_en	= exec && (op != OP_REDUCE);	// Reduce writes nothing

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		case (op)
			OP_BCAST:	result = scalar;
			OP_LANEID:	result = DATA_W'(LANE_ID);
			OP_ADD:		result = src1 + src2;
			OP_SUB:		result = src1 - src2;
			OP_AND:		result = src1 & src2;
			OP_XOR:		result = src1 ^ src2;
			OP_ADDI:	result = src1 + imm;		// Wraps at 32 bits
			OP_ROT:		result = rot_in;
			default:	result = '0;				// NOP and REDUCE
		endcase
	end

	assign chk_val = is_red ? src1 : result;		// Zero rule covers reduce operand

	////////////////////////////////////////
	// Register file and lane outputs
	////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
			commit		<= 1'b0;
			zero		<= 1'b0;
			red_val		<= '0;
			red_flag	<= 1'b0;
		end else begin
			if (wr_en) begin
				regs[rd] <= result;
			end
			commit		<= exec;						// One pulse per command
			zero		<= exec && (chk_val == '0);
			red_val		<= is_red ? src1 : '0;
			red_flag	<= is_red;
		end
	end

endmodule

`default_nettype wire

/* src/vec_commit.sv */
// Commit collector; status and scalar_out only move on a full commit, disabled lanes hold status
`timescale 1ns/1ps
`default_nettype none

module vec_commit (
	input	wire										clock,
	input	wire										arst_n,
	input	pkg_vec::lane_mask_t						iss_mask,	// Mask one edge early
	input	pkg_vec::lane_mask_t						commit,		// Per-lane commit
	input	pkg_vec::lane_mask_t						zero,		// Per-lane zero flag
	input	pkg_vec::data_t [pkg_vec::NUM_LANES-1:0]	red_val,	// Reduce operands
	input	pkg_vec::lane_mask_t						red_flag,	// Per-lane reduce
	output	logic										commit_req,	// All enabled lanes done
	output	pkg_vec::lane_mask_t						status,		// Sticky zero flags
	output	pkg_vec::data_t								scalar_out	// Reduce sum
);

	import pkg_vec::*;

	lane_mask_t	mask_d;		// Mask aligned with lane outputs
	logic		done;		// Every enabled lane committed
	logic		is_reduce;	// Reduce among enabled lanes
	data_t		red_sum;	// Wrapping sum of enabled operands

	////////////////////////////////////////
	// Compare and sum
	////////////////////////////////////////
	assign done			= (mask_d != '0) && (commit == mask_d);
	assign is_reduce	= |(red_flag & mask_d);

	always_comb begin
		red_sum = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (mask_d[i]) begin
				red_sum = red_sum + red_val[i];		// Mod 2^32
			end
		end
	end

	////////////////////////////////////////
	// Output registers
	////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			mask_d		<= '0;
			commit_req	<= 1'b0;
			status		<= '0;
			scalar_out	<= '0;
		end else begin
			mask_d		<= iss_mask;
			commit_req	<= done;
			if (done) begin
				status <= (status & ~mask_d) | (zero & mask_d);	// Keep disabled bits
			end
			if (done && is_reduce) begin
				scalar_out <= red_sum;
			end
		end
	end

endmodule

`default_nettype wire

/* src/vector_unit.sv */
// SIMD vector unit top; fixed 2-edge issue to commit_req, one command per cycle, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module vector_unit (
	input	wire					clock,
	input	wire					arst_n,
	input	pkg_vec::lane_mask_t	en_lane,		// Non-zero mask issues
	input	pkg_vec::cmd_word_t		command,		// Command word
	input	pkg_vec::data_t			scalar_in,		// Scalar operand
	output	logic					commit_req,		// Commit request
	output	pkg_vec::lane_mask_t	status,			// Lane status
	output	pkg_vec::data_t			scalar_out		// Reduce result
);

	import pkg_vec::*;

	lane_mask_t					iss_mask;		// Issued mask
	opcode_t					iss_op;
	reg_idx_t					iss_rd;
	reg_idx_t					iss_rs1;
	reg_idx_t					iss_rs2;
	data_t						iss_imm;
	data_t						iss_scalar;

	lane_mask_t					lane_commit;	// Commit bits from lanes
	lane_mask_t					lane_zero;		// Zero bits from lanes
	lane_mask_t					lane_red;		// Reduce flags from lanes
	data_t [NUM_LANES-1:0]		lane_red_val;	// Reduce operands
	data_t [NUM_LANES-1:0]		rot;			// Ring taps, rs1 per lane

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////
	vec_issue i_issue (
		.clock		(clock),
		.arst_n		(arst_n),
		.en_lane	(en_lane),
		.command	(command),
		.scalar_in	(scalar_in),
		.iss_mask	(iss_mask),
		.iss_op		(iss_op),
		.iss_rd		(iss_rd),
		.iss_rs1	(iss_rs1),
		.iss_rs2	(iss_rs2),
		.iss_imm	(iss_imm),
		.iss_scalar	(iss_scalar)
	);

	////////////////////////////////////////
	// Lane array and rotate ring
	////////////////////////////////////////
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		vec_lane #(
			.LANE_ID	(g)
		) i_lane (
			.clock		(clock),
			.arst_n		(arst_n),
			.en			(iss_mask[g]),
			.op			(iss_op),
			.rd			(iss_rd),
			.rs1		(iss_rs1),
			.rs2		(iss_rs2),
			.imm		(iss_imm),
			.scalar		(iss_scalar),
			.rot_in		(rot[(g+1) % NUM_LANES]),	// Top lane wraps to lane 0
			.rot_out	(rot[g]),
			.commit		(lane_commit[g]),
			.zero		(lane_zero[g]),
			.red_val	(lane_red_val[g]),
			.red_flag	(lane_red[g])
		);
	end

	////////////////////////////////////////
	// Output side
	////////////////////////////////////////
	vec_commit i_commit (
		.clock		(clock),
		.arst_n		(arst_n),
		.iss_mask	(iss_mask),
		.commit		(lane_commit),
		.zero		(lane_zero),
		.red_val	(lane_red_val),
		.red_flag	(lane_red),
		.commit_req	(commit_req),
		.status		(status),
		.scalar_out	(scalar_out)
	);

endmodule

`default_nettype wire

/* verification/vector_unit_chk.sv */
// Bound checker for vector_unit; samples on the rising clock, idle and status checks skip reset
`timescale 1ns/1ps
`default_nettype none

module vector_unit_chk (
	input	wire					clock,
	input	wire					arst_n,
	input	pkg_vec::lane_mask_t	en_lane,		// Issue mask at the DUT input
	input	wire					commit_req,
	input	pkg_vec::lane_mask_t	status
);

	////////////////////////////////////////
	// Commit and reset properties
	////////////////////////////////////////

	// Mask sampled three edges back is the one whose commit_req is seen now
	a_no_req_after_idle: assert property (@(posedge clock) disable iff (!arst_n)
		($past(en_lane, 3) == '0) |-> !commit_req)
		else $error("commit_req raised for an idle issue cycle");

	a_req_low_in_reset: assert property (@(posedge clock)
		!arst_n |-> !commit_req)
		else $error("commit_req high during reset");

	a_status_hold: assert property (@(posedge clock) disable iff (!arst_n)
		!commit_req |-> $stable(status))					// Moves only with a commit
		else $error("status changed without commit_req");

endmodule

bind vector_unit vector_unit_chk i_chk (
	.clock		(clock),
	.arst_n		(arst_n),
	.en_lane	(en_lane),
	.commit_req	(commit_req),
	.status		(status)
);

`default_nettype wire

/* verification/tb_vector_unit.sv */
// Testbench for vector_unit; stops at the first mismatch, one command in flight at a time
`timescale 1ns/1ps
`default_nettype none

module tb_vector_unit;

	import pkg_vec::*;

	localparam int			TIMEOUT_CYC		= 10;		// Max wait for commit_req
	localparam int			IDLE_CHECK_CYC	= 4;		// Quiet window after idle row
	localparam lane_mask_t	ALL_LANES		= '1;

	logic		clock;
	logic		arst_n;
	lane_mask_t	en_lane;
	cmd_word_t	command;
	data_t		scalar_in;
	logic		commit_req;
	lane_mask_t	status;
	data_t		scalar_out;

	integer		seed;								// $random state

	// Stimulus and expected values per row
	lane_mask_t	tab_mask [$];
	cmd_word_t	tab_cmd [$];
	data_t		tab_scalar [$];
	logic		tab_commit [$];						// commit_req expected
	lane_mask_t	tab_status [$];
	data_t		tab_sum [$];

	data_t		model_regs [NUM_LANES][NUM_REGS];	// Reference lane registers
	lane_mask_t	model_status;
	data_t		model_scalar;

	vector_unit i_dut (
		.clock		(clock),
		.arst_n		(arst_n),
		.en_lane	(en_lane),
		.command	(command),
		.scalar_in	(scalar_in),
		.commit_req	(commit_req),
		.status		(status),
		.scalar_out	(scalar_out)
	);

	always #50 clock = ~clock;						// 100 ns period

	////////////////////////////////////////
	// Compare and stop
	////////////////////////////////////////
	task automatic stop_on_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_mask(input string name, input lane_mask_t got, input lane_mask_t exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%01h expected 0x%01h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%01h expected 0x%01h", name, got, exp);
			stop_on_failure();
		end
	endtask

	////////////////////////////////////////
	// Command words and reference model
	////////////////////////////////////////
	function automatic cmd_word_t rr_word(input opcode_t op, input int rd, input int rs1,
			input int rs2);
		cmd_word_t w;
		w			= '0;
		w.rr.opcode	= op;
		w.rr.rd		= rd[REG_IDX_W-1:0];
		w.rr.rs1	= rs1[REG_IDX_W-1:0];
		w.rr.rs2	= rs2[REG_IDX_W-1:0];
		return w;
	endfunction

	function automatic cmd_word_t ri_word(input opcode_t op, input int rd, input int rs1,
			input int imm);
		cmd_word_t w;
		w			= '0;
		w.ri.opcode	= op;
		w.ri.rd		= rd[REG_IDX_W-1:0];
		w.ri.rs1	= rs1[REG_IDX_W-1:0];
		w.ri.imm	= imm[IMM_W-1:0];				// Two's complement field
		return w;
	endfunction

	// Runs one command on the model and stores the row with its expected results
	task automatic add_row(input lane_mask_t mask, input cmd_word_t cmd, input data_t scalar);
		data_t		old_rs1 [NUM_LANES];
		data_t		res;
		data_t		sum;
		data_t		imm_ext;
		int			imm_int;
		lane_mask_t	zbits;
		opcode_t	op;
		logic		commits;
		op		= cmd.rr.opcode;
		commits	= (mask != '0) && (op != OP_NOP);
		imm_int	= int'(cmd.ri.imm);					// Sign extends
		imm_ext	= data_t'(imm_int);
		sum		= '0;
		zbits	= '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			old_rs1[l] = model_regs[l][cmd.rr.rs1];	// Snapshot for rotate
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (commits && mask[l]) begin
				case (op)
					OP_BCAST:	res = scalar;
					OP_LANEID:	res = data_t'(l);
					OP_ADD:		res = old_rs1[l] + model_regs[l][cmd.rr.rs2];
					OP_SUB:		res = old_rs1[l] - model_regs[l][cmd.rr.rs2];
					OP_AND:		res = old_rs1[l] & model_regs[l][cmd.rr.rs2];
					OP_XOR:		res = old_rs1[l] ^ model_regs[l][cmd.rr.rs2];
					OP_ADDI:	res = old_rs1[l] + imm_ext;
					OP_ROT:		res = old_rs1[(l + 1) % NUM_LANES];	// Lane 3 from lane 0
					default:	res = old_rs1[l];						// Reduce operand
				endcase
				if (op == OP_REDUCE) begin
					sum = sum + res;
				end else begin
					model_regs[l][cmd.rr.rd] = res;
				end
				zbits[l] = (res == '0);
			end
		end
		if (commits) begin
			model_status = (model_status & ~mask) | (zbits & mask);
			if (op == OP_REDUCE) begin
				model_scalar = sum;
			end
		end
		tab_mask.push_back(mask);
		tab_cmd.push_back(cmd);
		tab_scalar.push_back(scalar);
		tab_commit.push_back(commits);
		tab_status.push_back(model_status);
		tab_sum.push_back(model_scalar);
	endtask

	////////////////////////////////////////
	// Command table
	////////////////////////////////////////
	task automatic build_rows();
		data_t		s_all;
		data_t		s_part;
		data_t		s_rand;
		lane_mask_t	m_rand;
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				model_regs[l][r] = '0;
			end
		end
		model_status	= '0;
		model_scalar	= '0;
		s_all			= data_t'($random(seed));
		s_part			= data_t'($random(seed));
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 5, 0), '0);	// Fresh register is zero
		add_row(ALL_LANES, rr_word(OP_BCAST, 1, 0, 0), s_all);
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 1, 0), '0);	// 4 x scalar
		add_row(ALL_LANES, rr_word(OP_LANEID, 2, 0, 0), '0);
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 2, 0), '0);	// 0+1+2+3
		add_row(ALL_LANES, rr_word(OP_BCAST, 3, 0, 0), 32'd5);
		add_row(ALL_LANES, ri_word(OP_ADDI, 4, 3, -7), '0);		// Negative immediate
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 4, 0), '0);
		add_row(ALL_LANES, rr_word(OP_ADD, 5, 1, 2), '0);
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 5, 0), '0);
		add_row(ALL_LANES, rr_word(OP_SUB, 6, 5, 1), '0);
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 6, 0), '0);
		add_row(ALL_LANES, rr_word(OP_AND, 7, 2, 3), '0);
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 7, 0), '0);
		add_row(ALL_LANES, rr_word(OP_XOR, 0, 3, 3), '0);		// All status bits set
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 0, 0), '0);
		add_row(ALL_LANES, rr_word(OP_ROT, 6, 2, 0), '0);
		for (int i = 0; i < NUM_LANES; i++) begin
			add_row(lane_mask_t'(1 << i), rr_word(OP_REDUCE, 0, 6, 0), '0);	// One lane each
		end
		add_row(4'b0101, rr_word(OP_BCAST, 7, 0, 0), s_part);	// Lanes 1 and 3 untouched
		add_row(4'b0000, rr_word(OP_BCAST, 7, 0, 0), '0);		// Idle mask is ignored
		add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 7, 0), '0);
		for (int k = 0; k < 4; k++) begin
			s_rand = data_t'($random(seed));
			m_rand = lane_mask_t'($random(seed)) | 4'b0001;
			add_row(m_rand, rr_word(OP_BCAST, 1, 0, 0), s_rand);
			add_row(ALL_LANES, rr_word(OP_ADD, 5, 1, 2), '0);
			add_row(ALL_LANES, rr_word(OP_REDUCE, 0, 5, 0), '0);
		end
	endtask

	////////////////////////////////////////
	// Apply one row
	////////////////////////////////////////
	task automatic apply_row(input int n);
		int waited;
		en_lane		= tab_mask[n];
		command		= tab_cmd[n];
		scalar_in	= tab_scalar[n];
		@(posedge clock);
		#1;
		en_lane		= '0;								// One idle cycle follows
		command		= '0;
		scalar_in	= '0;
		if (tab_commit[n]) begin
			waited = 0;
			do begin
				@(posedge clock);
				#1;
				waited++;
			end while (!commit_req && waited < TIMEOUT_CYC);
			if (!commit_req) begin
				$display("commit request never arrived on row %0d", n);
				stop_on_failure();
			end
			check_mask("status", status, tab_status[n]);
			check_data("scalar_out", scalar_out, tab_sum[n]);	// Holds on non-reduce rows
		end else begin
			for (int c = 0; c < IDLE_CHECK_CYC; c++) begin
				@(posedge clock);
				#1;
				check_bit("commit_req", commit_req, 1'b0);
			end
		end
	endtask

	initial begin
		seed		= 32'h77e9;
		clock		= 1'b0;
		arst_n		= 1'b0;
		en_lane		= '0;
		command		= '0;
		scalar_in	= '0;
		build_rows();
		repeat (8) @(posedge clock);					// Reset for 8 cycles
		#1;
		arst_n = 1'b1;
		check_bit("commit_req", commit_req, 1'b0);
		check_mask("status", status, '0);
		check_data("scalar_out", scalar_out, '0);
		for (int n = 0; n < tab_mask.size(); n++) begin
			apply_row(n);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
src/pkg_vec.sv
src/vec_issue.sv
src/vec_lane.sv
src/vec_commit.sv
src/vector_unit.sv
verification/vector_unit_chk.sv
verification/tb_vector_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the vector unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_vector_unit \
	-f filelist.f \
	-o sim_vector_unit

out=$(./obj_dir/sim_vector_unit 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1
